// ==== src/bp_consts.svh ====
// sizes of the predictor; the index field must fit inside the pc width above the stride bits
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// width of fetch and target addresses
`define BP_PC_WIDTH 32

// table index bits, 256 fetch-pair slots
`define BP_INDEX_WIDTH 8

// lowest pc bit of the index
// bits below it address inside the fetch pair
`define BP_INDEX_LSB 3

// fall-through increment, two 32-bit instructions per fetch
`define BP_FETCH_STRIDE 8

`endif

// ==== src/bp_pkg.sv ====
// enum types only; encodings are fixed because the predecoder and the counters rely on them
`default_nettype none

package bp_pkg;

    // predecoder class of the instruction at the fetch pc
    typedef enum logic [1:0] {
        br_none     = 2'd0,
        br_uncond   = 2'd1,
        br_relative = 2'd2,
        br_indirect = 2'd3
    } branch_type_e;

    // 2-bit direction counter
    // bit 0 low means the counter predicts taken
    typedef enum logic [1:0] {
        ctr_strong_taken     = 2'b00,
        ctr_strong_not_taken = 2'b01,
        ctr_weak_taken       = 2'b10,
        ctr_weak_not_taken   = 2'b11
    } counter_state_e;

    // which counter drives the direction
    // sel_static is only ever the reset state
    typedef enum logic [1:0] {
        sel_static = 2'd0,
        sel_easy   = 2'd1,
        sel_hard   = 2'd2
    } chooser_e;

endpackage : bp_pkg

`default_nettype wire

// ==== src/target_ram.sv ====
// contents are not reset; a read of the address written in the same cycle returns the old word
`timescale 1ns/100ps
`default_nettype none

module target_ram #(
    parameter int data_width = 32,
    parameter int addr_width = 8
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] rd_data,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data
);

    localparam int depth = 1 << addr_width;

    logic [data_width-1:0] mem [0:depth-1];

    // synchronous write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // asynchronous read, sees the array before the edge
    assign rd_data = mem[rd_addr];

endmodule : target_ram

`default_nettype wire

// ==== src/dir_predictor.sv ====
// one global direction state shared by all branches; it predicts not taken until the first resolve
`timescale 1ns/100ps
`default_nettype none

module dir_predictor
    import bp_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic resolve_valid,
    input  logic fact_taken,
    input  logic dir_fail,
    output logic dir_taken
);

    counter_state_e easy_q;
    counter_state_e easy_d;
    counter_state_e hard_q;
    counter_state_e hard_d;
    logic [1:0]     score_q;
    logic [1:0]     score_d;
    chooser_e       mode_q;
    logic           hit;

    function automatic logic ctr_taken(input counter_state_e ctr);
        return (ctr == ctr_strong_taken) || (ctr == ctr_weak_taken);
    endfunction

    assign hit = ~dir_fail;

    // easy counter jumps straight to the outcome side
    always_comb begin
        if (fact_taken) begin
            easy_d = ctr_taken(easy_q) ? ctr_strong_taken : ctr_weak_taken;
        end else begin
            easy_d = ctr_taken(easy_q) ? ctr_weak_not_taken : ctr_strong_not_taken;
        end
    end

    // hard counter saturates, one step per resolve
    always_comb begin
        case (hard_q)
            ctr_strong_taken: begin
                hard_d = fact_taken ? ctr_strong_taken : ctr_weak_taken;
            end
            ctr_weak_taken: begin
                hard_d = fact_taken ? ctr_strong_taken : ctr_weak_not_taken;
            end
            ctr_weak_not_taken: begin
                hard_d = fact_taken ? ctr_weak_taken : ctr_strong_not_taken;
            end
            ctr_strong_not_taken: begin
                hard_d = fact_taken ? ctr_weak_not_taken : ctr_strong_not_taken;
            end
            default: begin
                hard_d = ctr_weak_taken;
            end
        endcase
    end

    // chooser score; misses push it across the top bit, hits settle it
    always_comb begin
        case (score_q)
            2'd0:    score_d = hit ? 2'd0 : 2'd1;
            2'd1:    score_d = hit ? 2'd0 : 2'd2;
            2'd2:    score_d = hit ? 2'd3 : 2'd1;
            default: score_d = hit ? 2'd3 : 2'd2;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            easy_q  <= ctr_weak_taken;
            hard_q  <= ctr_weak_taken;
            score_q <= 2'd0;
            mode_q  <= sel_static;
        end else if (resolve_valid) begin
            easy_q  <= easy_d;
            hard_q  <= hard_d;
            score_q <= score_d;
            // mode follows the updated score, never returns to static
            mode_q  <= score_d[1] ? sel_easy : sel_hard;
        end
    end

    always_comb begin
        case (mode_q)
            sel_easy: begin
                dir_taken = ctr_taken(easy_q);
            end
            sel_hard: begin
                dir_taken = ctr_taken(hard_q);
            end
            sel_static: begin
                dir_taken = 1'b0;
            end
            default: begin
                dir_taken = 1'b0;
            end
        endcase
    end

endmodule : dir_predictor

`default_nettype wire

// ==== src/btb.sv ====
// direct-mapped without tags, so pcs sharing index bits alias; a br_none fetch clears its slot
`timescale 1ns/100ps
`default_nettype none
`include "bp_consts.svh"

module btb
    import bp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`BP_PC_WIDTH-1:0] fetch_pc,
    input  branch_type_e            inst_btype,
    input  logic                    resolve_valid,
    input  logic [`BP_PC_WIDTH-1:0] fact_pc,
    input  logic [`BP_PC_WIDTH-1:0] fact_tpc,
    input  logic                    fact_taken,
    input  logic                    addr_fail,
    input  logic                    dir_taken,
    output logic [`BP_PC_WIDTH-1:0] pred_pc,
    output logic                    pred_taken
);

    localparam int num_slots = 1 << `BP_INDEX_WIDTH;
    localparam logic [`BP_PC_WIDTH-1:0] fetch_stride = `BP_FETCH_STRIDE;

    logic [num_slots-1:0]          valid_mask;
    logic [`BP_INDEX_WIDTH-1:0]    fetch_idx;
    logic [`BP_INDEX_WIDTH-1:0]    wr_idx;
    logic [`BP_PC_WIDTH-1:0]       stored_target;
    logic                          wr_en;
    logic                          clear_en;
    logic                          slot_valid;
    logic                          branch_taken;

    assign fetch_idx = fetch_pc[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    assign wr_idx    = fact_pc[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];

    // install a target only when execute found a taken branch we got wrong
    assign wr_en = resolve_valid & fact_taken & addr_fail;

    // not gated by the resolve strobe; a write to the same slot wins
    assign clear_en = (inst_btype == br_none) && !(wr_en && (wr_idx == fetch_idx));

    target_ram #(
        .data_width(`BP_PC_WIDTH),
        .addr_width(`BP_INDEX_WIDTH)
    ) u_target_ram (
        .clk    (clk),
        .rd_addr(fetch_idx),
        .rd_data(stored_target),
        .wr_en  (wr_en),
        .wr_addr(wr_idx),
        .wr_data(fact_tpc)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_mask <= '0;
        end else begin
            if (clear_en) begin
                valid_mask[fetch_idx] <= 1'b0;
            end
            if (wr_en) begin
                valid_mask[wr_idx] <= 1'b1;
            end
        end
    end

    assign slot_valid = valid_mask[fetch_idx];

    // unconditional kinds always jump, relative ones ask the direction predictor
    always_comb begin
        case (inst_btype)
            br_uncond:   branch_taken = 1'b1;
            br_indirect: branch_taken = 1'b1;
            br_relative: branch_taken = dir_taken;
            default:     branch_taken = 1'b0;
        endcase
    end

    assign pred_taken = slot_valid & branch_taken;

    // a stored target is offered on any hit, even when not taken is predicted
    assign pred_pc = slot_valid ? stored_target : fetch_pc + fetch_stride;

endmodule : btb

`default_nettype wire

// ==== src/branch_predictor.sv ====
// prediction is combinational from fetch_pc; all updates wait for the execute resolve strobe
`timescale 1ns/100ps
`default_nettype none
`include "bp_consts.svh"

module branch_predictor
    import bp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`BP_PC_WIDTH-1:0] fetch_pc,
    input  branch_type_e            inst_btype,
    input  logic                    resolve_valid,
    input  logic [`BP_PC_WIDTH-1:0] fact_pc,
    input  logic [`BP_PC_WIDTH-1:0] fact_tpc,
    input  logic                    fact_taken,
    input  logic                    dir_fail,
    input  logic                    addr_fail,
    output logic [`BP_PC_WIDTH-1:0] pred_pc,
    output logic                    pred_taken
);

    logic dir_taken;

    dir_predictor u_dir_predictor (
        .clk          (clk),
        .rstn         (rstn),
        .resolve_valid(resolve_valid),
        .fact_taken   (fact_taken),
        .dir_fail     (dir_fail),
        .dir_taken    (dir_taken)
    );

    btb u_btb (
        .clk          (clk),
        .rstn         (rstn),
        .fetch_pc     (fetch_pc),
        .inst_btype   (inst_btype),
        .resolve_valid(resolve_valid),
        .fact_pc      (fact_pc),
        .fact_tpc     (fact_tpc),
        .fact_taken   (fact_taken),
        .addr_fail    (addr_fail),
        .dir_taken    (dir_taken),
        .pred_pc      (pred_pc),
        .pred_taken   (pred_taken)
    );

endmodule : branch_predictor

`default_nettype wire

// ==== test/branch_predictor_checker.sv ====
// bound to btb; assertions sample at the rising edge and most are off while reset is held
`timescale 1ns/100ps
`default_nettype none
`include "bp_consts.svh"

module branch_predictor_checker
    import bp_pkg::*;
(
    input logic                    clk,
    input logic                    rstn,
    input logic [`BP_PC_WIDTH-1:0] fetch_pc,
    input branch_type_e            inst_btype,
    input logic                    slot_valid,
    input logic [`BP_PC_WIDTH-1:0] pred_pc,
    input logic                    pred_taken
);

    localparam logic [`BP_PC_WIDTH-1:0] fetch_stride = `BP_FETCH_STRIDE;

    // a non-branch never redirects fetch
    no_taken_on_non_branch: assert property (
        @(posedge clk) disable iff (!rstn)
        (inst_btype == br_none) |-> !pred_taken
    ) else $error("pred_taken is high for a non-branch fetch");

    // empty slot means sequential fetch
    fall_through_on_miss: assert property (
        @(posedge clk) disable iff (!rstn)
        !slot_valid |-> (pred_pc == fetch_pc + fetch_stride)
    ) else $error("pred_pc is not the fall-through address on a table miss");

    // table is empty right after reset
    quiet_after_reset: assert property (
        @(posedge clk)
        $rose(rstn) |-> !pred_taken
    ) else $error("pred_taken is high in the first cycle after reset");

endmodule : branch_predictor_checker

bind btb branch_predictor_checker u_branch_predictor_checker (
    .clk       (clk),
    .rstn      (rstn),
    .fetch_pc  (fetch_pc),
    .inst_btype(inst_btype),
    .slot_valid(slot_valid),
    .pred_pc   (pred_pc),
    .pred_taken(pred_taken)
);

`default_nettype wire

// ==== test/branch_predictor_tb.sv ====
// model assumes target words are only read from slots it has written; random pcs use 16 slots
`timescale 1ns/100ps
`default_nettype none
`include "bp_consts.svh"

module branch_predictor_tb
    import bp_pkg::*;
();

    localparam int clk_period    = 100;
    localparam int num_slots     = 1 << `BP_INDEX_WIDTH;
    localparam int reset_timeout = 20;
    localparam int drain_timeout = 10;
    localparam int random_cycles = 2000;
    localparam logic [`BP_PC_WIDTH-1:0] stride = `BP_FETCH_STRIDE;
    // conditional resolve series where bit i is step i
    localparam logic [11:0] pat_taken = 12'b1011_0010_1100;
    localparam logic [11:0] pat_fail  = 12'b0011_1011_0011;

    logic                    clk;
    logic                    rstn;
    logic [`BP_PC_WIDTH-1:0] fetch_pc;
    branch_type_e            inst_btype;
    logic                    resolve_valid;
    logic [`BP_PC_WIDTH-1:0] fact_pc;
    logic [`BP_PC_WIDTH-1:0] fact_tpc;
    logic                    fact_taken;
    logic                    dir_fail;
    logic                    addr_fail;
    logic [`BP_PC_WIDTH-1:0] pred_pc;
    logic                    pred_taken;

    // reference model state
    logic                    m_valid [num_slots];
    logic [`BP_PC_WIDTH-1:0] m_target [num_slots];
    counter_state_e          m_easy;
    counter_state_e          m_hard;
    logic [1:0]              m_score;
    chooser_e                m_mode;
    int                      num_checks;

    branch_predictor u_branch_predictor (
        .clk          (clk),
        .rstn         (rstn),
        .fetch_pc     (fetch_pc),
        .inst_btype   (inst_btype),
        .resolve_valid(resolve_valid),
        .fact_pc      (fact_pc),
        .fact_tpc     (fact_tpc),
        .fact_taken   (fact_taken),
        .dir_fail     (dir_fail),
        .addr_fail    (addr_fail),
        .pred_pc      (pred_pc),
        .pred_taken   (pred_taken)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [`BP_INDEX_WIDTH-1:0] slot_of(input logic [`BP_PC_WIDTH-1:0] pc);
        return pc[`BP_INDEX_LSB +: `BP_INDEX_WIDTH];
    endfunction

    function automatic logic says_taken(input counter_state_e c);
        return c inside {ctr_strong_taken, ctr_weak_taken};
    endfunction

    // saturating counter as a level where 0 is strong not taken
    function automatic counter_state_e hard_step(input counter_state_e c, input logic taken);
        int level;
        case (c)
            ctr_strong_not_taken: level = 0;
            ctr_weak_not_taken:   level = 1;
            ctr_weak_taken:       level = 2;
            default:              level = 3;
        endcase
        if (taken && level < 3) begin
            level = level + 1;
        end else if (!taken && level > 0) begin
            level = level - 1;
        end
        case (level)
            0:       return ctr_strong_not_taken;
            1:       return ctr_weak_not_taken;
            2:       return ctr_weak_taken;
            default: return ctr_strong_taken;
        endcase
    endfunction

    function automatic void predict_ref(
        input  logic [`BP_PC_WIDTH-1:0] pc,
        input  branch_type_e            btype,
        output logic [`BP_PC_WIDTH-1:0] exp_pc,
        output logic                    exp_taken
    );
        logic                       dir;
        logic [`BP_INDEX_WIDTH-1:0] idx;
        idx = slot_of(pc);
        case (m_mode)
            sel_easy: dir = says_taken(m_easy);
            sel_hard: dir = says_taken(m_hard);
            default:  dir = 1'b0;
        endcase
        exp_pc = m_valid[idx] ? m_target[idx] : pc + stride;
        exp_taken = m_valid[idx] && ((btype == br_uncond) || (btype == br_indirect) ||
                                     (btype == br_relative && dir));
    endfunction

    task automatic reset_model();
        for (int i = 0; i < num_slots; i++) begin
            m_valid[i] = 1'b0;
        end
        m_easy  = ctr_weak_taken;
        m_hard  = ctr_weak_taken;
        m_score = 2'd0;
        m_mode  = sel_static;
    endtask

    // applies what the DUT will see at the coming edge
    task automatic update_model();
        logic                       wr;
        logic [`BP_INDEX_WIDTH-1:0] widx;
        logic [`BP_INDEX_WIDTH-1:0] fidx;
        wr   = resolve_valid && fact_taken && addr_fail;
        widx = slot_of(fact_pc);
        fidx = slot_of(fetch_pc);
        if (inst_btype == br_none && !(wr && widx == fidx)) begin
            m_valid[fidx] = 1'b0;
        end
        if (wr) begin
            m_valid[widx]  = 1'b1;
            m_target[widx] = fact_tpc;
        end
        if (resolve_valid) begin
            if (fact_taken) begin
                m_easy = says_taken(m_easy) ? ctr_strong_taken : ctr_weak_taken;
            end else begin
                m_easy = says_taken(m_easy) ? ctr_weak_not_taken : ctr_strong_not_taken;
            end
            m_hard = hard_step(m_hard, fact_taken);
            if (!dir_fail) begin
                m_score = m_score[1] ? 2'd3 : 2'd0;
            end else if (m_score[1]) begin
                m_score = m_score - 2'd1;
            end else begin
                m_score = m_score + 2'd1;
            end
            m_mode = m_score[1] ? sel_easy : sel_hard;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_pc(
        input logic [`BP_PC_WIDTH-1:0] actual,
        input logic [`BP_PC_WIDTH-1:0] expected,
        input string                   what
    );
        if (actual !== expected) begin
            $display("Error: time %0t: %s pred_pc is %h, expected %h", $time, what, actual,
                     expected);
            abort_run("pred_pc does not match the reference model");
        end
    endtask

    task automatic check_taken(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Error: time %0t: %s pred_taken is %b, expected %b", $time, what, actual,
                     expected);
            abort_run("pred_taken does not match the reference model");
        end
    endtask

    // compare just before each rising edge and then advance the model
    initial begin : compare_outputs
        logic [`BP_PC_WIDTH-1:0] exp_pc;
        logic                    exp_taken;
        string                   ctx;
        num_checks = 0;
        reset_model();
        forever begin
            @(posedge clk);
            #(clk_period - 1);
            if (!rstn) begin
                reset_model();
            end else begin
                predict_ref(fetch_pc, inst_btype, exp_pc, exp_taken);
                ctx = $sformatf("fetch_pc %h type %s:", fetch_pc, inst_btype.name());
                check_pc(pred_pc, exp_pc, ctx);
                check_taken(pred_taken, exp_taken, ctx);
                update_model();
                num_checks++;
            end
        end
    end

    task automatic drive_cycle(
        input logic [`BP_PC_WIDTH-1:0] pc,
        input branch_type_e            btype,
        input logic                    rv,
        input logic [`BP_PC_WIDTH-1:0] fpc,
        input logic [`BP_PC_WIDTH-1:0] ftpc,
        input logic                    ftaken,
        input logic                    dfail,
        input logic                    afail
    );
        @(posedge clk);
        fetch_pc      <= pc;
        inst_btype    <= btype;
        resolve_valid <= rv;
        fact_pc       <= fpc;
        fact_tpc      <= ftpc;
        fact_taken    <= ftaken;
        dir_fail      <= dfail;
        addr_fail     <= afail;
    endtask

    task automatic lookup(input logic [`BP_PC_WIDTH-1:0] pc, input branch_type_e btype);
        drive_cycle(pc, btype, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic wait_for_reset_release();
        int cycles;
        cycles = 0;
        while (rstn !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > reset_timeout) begin
                abort_run("reset was not released in time");
            end
        end
    endtask

    task automatic wait_for_last_check(input int base);
        int cycles;
        cycles = 0;
        while (num_checks <= base) begin
            @(posedge clk);
            cycles++;
            if (cycles > drain_timeout) begin
                abort_run("the compare process stopped checking outputs");
            end
        end
    endtask

    initial begin : stimulus
        logic [31:0]             r;
        logic [31:0]             r2;
        logic [`BP_PC_WIDTH-1:0] pc;
        int                      base;
        void'($urandom(32'h114aff9e));
        rstn          = 1'b0;
        fetch_pc      = '0;
        inst_btype    = br_uncond;
        resolve_valid = 1'b0;
        fact_pc       = '0;
        fact_tpc      = '0;
        fact_taken    = 1'b0;
        dir_fail      = 1'b0;
        addr_fail     = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        wait_for_reset_release();

        // empty table falls through for every type
        for (int k = 0; k < 8; k++) begin
            for (int t = 0; t < 4; t++) begin
                pc = 32'h0000_0248 * k;
                lookup(pc, branch_type_e'(t[1:0]));
            end
        end

        // install and hit including an aliasing pc
        drive_cycle(32'h0000_0100, br_uncond, 1'b1, 32'h0000_1000, 32'h0000_2000,
                    1'b1, 1'b0, 1'b1);
        lookup(32'h0000_1000, br_uncond);
        lookup(32'h0000_1004, br_indirect);
        lookup(32'h0000_1800, br_uncond);
        lookup(32'h0000_1000, br_relative);

        // br_none clears and a same-slot write wins
        lookup(32'h0000_1000, br_none);
        lookup(32'h0000_1000, br_uncond);
        drive_cycle(32'h0000_1000, br_none, 1'b1, 32'h0000_1000, 32'h0000_2400,
                    1'b1, 1'b0, 1'b1);
        lookup(32'h0000_1000, br_uncond);

        // score walks across its top bit
        drive_cycle(32'h0000_0100, br_uncond, 1'b1, 32'h0000_3000, 32'h0000_3400,
                    1'b1, 1'b0, 1'b1);
        for (int i = 0; i < 12; i++) begin
            drive_cycle(32'h0000_3000, br_relative, 1'b1, 32'h0000_3000, 32'h0000_3400,
                        pat_taken[i], pat_fail[i], 1'b0);
            lookup(32'h0000_3000, br_relative);
        end

        // strobe low with the other fields active
        drive_cycle(32'h0000_3000, br_relative, 1'b0, 32'h0000_3000, 32'h0000_5000,
                    1'b1, 1'b1, 1'b1);
        lookup(32'h0000_3000, br_relative);
        lookup(32'h0000_3000, br_uncond);

        for (int i = 0; i < random_cycles; i++) begin
            r  = $urandom;
            r2 = $urandom;
            drive_cycle(32'h0000_4000 + {25'd0, r[3:0], r[4], 2'b00},
                        branch_type_e'(r[11:10]), r[12],
                        32'h0000_4000 + {25'd0, r[8:5], r[9], 2'b00},
                        {r2[31:2], 2'b00}, r[13], r[14], r[15]);
        end

        base = num_checks;
        wait_for_last_check(base);
        $display("TEST PASSED");
        $finish;
    end

endmodule : branch_predictor_tb

`default_nettype wire

// ==== branch_predictor.f ====
+incdir+src
src/bp_pkg.sv
src/target_ram.sv
src/dir_predictor.sv
src/btb.sv
src/branch_predictor.sv
test/branch_predictor_checker.sv
test/branch_predictor_tb.sv

// ==== Makefile ====
# Verilator build and run of the branch predictor testbench

TOP := branch_predictor_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f branch_predictor.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -Wall -f branch_predictor.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
